/* hw/cm_pkg.sv */
// Beverage dispenser shared types
package cm_pkg;

	// ############################
	// Sizes and widths
	// ############################
	localparam int NUM_TANKS = 4;
	localparam int LEVEL_W = 10;

	// Tank level or cup volume
	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [2:0] ratio_t;
	typedef logic [3:0] ratio_sum_t;
	// Espresso, milk, chocolate, froth
	typedef logic [1:0] tank_idx_t;

	typedef enum logic [2:0] {none, espresso, milk, chocolate, froth} tank_e;
	typedef enum logic [2:0] {no_coffee, latte, cappuccino, mocha} flavor_e;
	typedef enum logic [2:0] {no_size, s, m, l, xl} size_e;
	typedef enum logic {red, green} led_e;

	// One ratio per tank, index 0 is espresso
	typedef ratio_t [0:NUM_TANKS-1] recipe_t;

	// Divider remainder holds one bit more than the divisor
	localparam int DIV_REM_W = $bits(ratio_sum_t) + 1;
	localparam int DIV_CNT_W = $clog2(LEVEL_W);

	// ############################
	// Cup volumes and recipes
	// ############################
	localparam level_t CUP_S = 10'd240;
	localparam level_t CUP_M = 10'd360;
	localparam level_t CUP_L = 10'd480;
	localparam level_t CUP_XL = 10'd600;

	localparam recipe_t LATTE_RATIO = '{3'd2, 3'd1, 3'd0, 3'd2};
	localparam recipe_t CAPPUCCINO_RATIO = '{3'd2, 3'd1, 3'd0, 3'd1};
	localparam recipe_t MOCHA_RATIO = '{3'd1, 3'd1, 3'd1, 3'd0};

	// Divisor for the portion split
	function automatic ratio_sum_t recipe_sum(input recipe_t r);
		ratio_sum_t acc;
		acc = '0;
		for (int i = 0; i < NUM_TANKS; i++)
		begin
			acc = acc + ratio_sum_t'(r[i]);
		end
		return acc;
	endfunction

endpackage

/* hw/brew_if.sv */
// Refill and brew link
interface brew_if import cm_pkg::*; ();

	// Refill strobes
	logic fill_en;
	tank_idx_t fill_tank;
	level_t fill_amount;
	logic fill_end;

	// Order, steady from start until done
	logic start;
	level_t volume;
	ratio_sum_t ratio_sum;
	recipe_t ratio;
	flavor_e flavor;

	// Divider result
	level_t quotient;
	logic done;

	modport seq (output fill_en, fill_tank, fill_amount, fill_end, start, volume, ratio_sum,
		ratio, flavor, input done);
	modport div (input start, volume, ratio_sum, output quotient, done);
	modport tank (input fill_en, fill_tank, fill_amount, fill_end, ratio, flavor, quotient, done);

endinterface

/* hw/order_sequencer.sv */
// Order and refill sequencer
module order_sequencer import cm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input tank_e select_i,
	input level_t supply,
	input flavor_e flavor_btn,
	input size_e required_size,
	brew_if.seq bus
);

	typedef enum logic [1:0] {st_idle, st_fill, st_brew} seq_state_e;

	seq_state_e state;
	seq_state_e state_nx;
	logic brew_press;
	logic accept;
	level_t cup_volume;
	recipe_t recipe;

	// Only the three fixed recipes start a brew
	assign brew_press = (flavor_btn == latte) || (flavor_btn == cappuccino) ||
		(flavor_btn == mocha);
	// Refill wins over a button in the same cycle
	assign accept = (state == st_idle) && (select_i == none) && brew_press;

	// ############################
	// State machine
	// ############################
	always_comb
	begin
		state_nx = state;
		case (state)
			st_idle:
			begin
				if (select_i != none)
					state_nx = st_fill;
				else if (brew_press)
					state_nx = st_brew;
			end
			st_fill:
			begin
				if (select_i == none)
					state_nx = st_idle;
			end
			st_brew:
			begin
				// Everything ignored until the divider reports
				if (bus.done)
					state_nx = st_idle;
			end
			default:
			begin
				state_nx = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			bus.start <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			// Start follows the accepting edge by one cycle
			bus.start <= accept;
		end
	end

	// ############################
	// Refill strobes
	// ############################
	always_comb
	begin
		bus.fill_en = (state != st_brew) && (select_i != none);
		bus.fill_amount = supply;
		bus.fill_end = (state == st_fill) && (select_i == none);
		case (select_i)
			milk: bus.fill_tank = 2'd1;
			chocolate: bus.fill_tank = 2'd2;
			froth: bus.fill_tank = 2'd3;
			default: bus.fill_tank = 2'd0;
		endcase
	end

	// Size and recipe lookup
	always_comb
	begin
		case (required_size)
			s: cup_volume = CUP_S;
			m: cup_volume = CUP_M;
			l: cup_volume = CUP_L;
			xl: cup_volume = CUP_XL;
			default: cup_volume = '0;
		endcase
		case (flavor_btn)
			latte: recipe = LATTE_RATIO;
			cappuccino: recipe = CAPPUCCINO_RATIO;
			mocha: recipe = MOCHA_RATIO;
			default: recipe = '0;
		endcase
	end

	// Order latch
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			bus.flavor <= flavor_btn;
			bus.volume <= cup_volume;
			bus.ratio <= recipe;
			bus.ratio_sum <= recipe_sum(recipe);
		end
	end

	// One brew at a time, the divider answers after its last bit step
	a_brew_done: assert property (@(posedge clk) disable iff (!rst_n)
		bus.start |-> ##(LEVEL_W + 1) bus.done);

endmodule

/* hw/portion_divider.sv */
// Restoring portion divider
module portion_divider import cm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	brew_if.div bus
);

	logic busy;
	logic [DIV_CNT_W-1:0] bit_cnt;
	logic [DIV_REM_W-1:0] rem_q;
	level_t quo_q;
	logic [DIV_REM_W-1:0] rem_shift;
	logic [DIV_REM_W-1:0] rem_diff;
	logic fits;

	// ############################
	// One quotient bit per cycle
	// ############################
	// Next dividend bit enters the remainder
	assign rem_shift = {rem_q[DIV_REM_W-2:0], quo_q[LEVEL_W-1]};
	assign rem_diff = rem_shift - {1'b0, bus.ratio_sum};
	assign fits = (rem_shift >= {1'b0, bus.ratio_sum});

	// Control
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
			bus.done <= 1'b0;
		end
		else if (bus.start)
		begin
			busy <= 1'b1;
			bit_cnt <= '0;
			bus.done <= 1'b0;
		end
		else if (busy)
		begin
			bit_cnt <= bit_cnt + 1'b1;
			// Last bit resolved, done in the following cycle
			if (bit_cnt == DIV_CNT_W'(LEVEL_W - 1))
			begin
				busy <= 1'b0;
				bus.done <= 1'b1;
			end
		end
		else
		begin
			bus.done <= 1'b0;
		end
	end

	// Shift register, dividend bits leave as quotient bits arrive
	always_ff @(posedge clk)
	begin
		if (bus.start)
		begin
			rem_q <= '0;
			quo_q <= bus.volume;
		end
		else if (busy)
		begin
			rem_q <= fits ? rem_diff : rem_shift;
			quo_q <= {quo_q[LEVEL_W-2:0], fits};
		end
	end

	assign bus.quotient = quo_q;

	// Sequencer never hands over an empty recipe
	a_divisor_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		bus.start |-> (bus.ratio_sum != '0));

endmodule

/* hw/tank_bank.sv */
// Ingredient tanks and result port
module tank_bank import cm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	brew_if.tank bus,
	output logic out_valid,
	output flavor_e flavor_out,
	output level_t tank_level [NUM_TANKS],
	output led_e tank_led [NUM_TANKS]
);

	level_t need [NUM_TANKS];
	level_t remain [NUM_TANKS];
	logic [NUM_TANKS-1:0] lacking;
	logic can_make;

	// ############################
	// Brew feasibility
	// ############################
	always_comb
	begin
		for (int i = 0; i < NUM_TANKS; i++)
		begin
			// Share never exceeds the cup volume
			need[i] = level_t'(bus.quotient * bus.ratio[i]);
			lacking[i] = (tank_level[i] < need[i]);
			remain[i] = tank_level[i] - need[i];
		end
		// All four tanks must cover their share
		can_make = ~|lacking;
	end

	// ############################
	// Levels and lamps
	// ############################
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_TANKS; i++)
			begin
				tank_level[i] <= '0;
				tank_led[i] <= red;
			end
		end
		else if (bus.fill_en)
		begin
			// Wraps modulo 1024
			tank_level[bus.fill_tank] <= tank_level[bus.fill_tank] + bus.fill_amount;
		end
		else if (bus.fill_end)
		begin
			for (int i = 0; i < NUM_TANKS; i++)
			begin
				tank_led[i] <= (tank_level[i] != '0) ? green : red;
			end
		end
		else if (bus.done)
		begin
			for (int i = 0; i < NUM_TANKS; i++)
			begin
				if (can_make)
				begin
					tank_level[i] <= remain[i];
					tank_led[i] <= (remain[i] != '0) ? green : red;
				end
				else
				begin
					// Levels kept, lamps flag the short or empty tanks
					tank_led[i] <= (lacking[i] || tank_level[i] == '0) ? red : green;
				end
			end
		end
	end

	// Result pulse
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			flavor_out <= no_coffee;
		end
		else
		begin
			out_valid <= bus.fill_end || bus.done;
			flavor_out <= (bus.done && can_make) ? bus.flavor : no_coffee;
		end
	end

	// Single pulse per operation
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid);

endmodule

/* hw/cm_top.sv */
// Beverage dispenser top
module cm_top import cm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input tank_e select_i,
	input level_t supply,
	input flavor_e flavor_btn,
	input size_e required_size,
	output logic out_valid,
	output flavor_e flavor_out,
	output level_t tank_level [NUM_TANKS],
	output led_e tank_led [NUM_TANKS]
);

	// Link between the three blocks
	brew_if bus ();

	// Buttons and refill selection
	order_sequencer u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.select_i(select_i),
		.supply(supply),
		.flavor_btn(flavor_btn),
		.required_size(required_size),
		.bus(bus.seq)
	);

	// Volume over ratio sum
	portion_divider u_div (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.div)
	);

	// Levels, lamps and result
	tank_bank u_tank (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.tank),
		.out_valid(out_valid),
		.flavor_out(flavor_out),
		.tank_level(tank_level),
		.tank_led(tank_led)
	);

endmodule

/* bench/tb_clock.sv */
// Clock and reset source
module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

	// Release lands clear of a rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(PERIOD / 10);
		rst_n = 1'b1;
	end

endmodule

/* bench/cm_checker.sv */
// Dispenser result checker
module cm_checker import cm_pkg::*;
#(
	parameter int FIELDS = 12,
	parameter int MAX_OPS = 64
)
(
	input logic clk,
	input logic rst_n,
	input logic out_valid,
	input flavor_e flavor_out,
	input level_t tank_level [NUM_TANKS],
	input led_e tank_led [NUM_TANKS],
	output int errors,
	output int results
);

	// Same golden table as the stimulus side
	logic [11:0] gold [0:FIELDS*MAX_OPS-1];
	int n_ops;

	task automatic report(input string msg);
		errors++;
		$display("CHECK FAILED at time %0t: %s", $time, msg);
	endtask

	// ##############################
	// Reset values
	// ##############################
	task automatic check_reset();
		if (out_valid)
			report("out_valid high right after reset");
		if (flavor_out != no_coffee)
			report($sformatf("flavor_out %s after reset, expected no_coffee", flavor_out.name()));
		for (int i = 0; i < NUM_TANKS; i++)
		begin
			if (tank_level[i] != '0)
				report($sformatf("tank %0d level %0d after reset, expected 0", i, tank_level[i]));
			if (tank_led[i] != red)
				report($sformatf("tank %0d lamp %s after reset, expected red", i,
					tank_led[i].name()));
		end
	endtask

	// ##############################
	// One result against its line
	// ##############################
	task automatic compare_result(input int k);
		int base;
		flavor_e exp_flavor;
		level_t exp_level;
		led_e exp_led;
		base = k * FIELDS;
		// Field 6 flavor, 7 to 10 levels, 11 lamp bits
		exp_flavor = flavor_e'(gold[base + 6][2:0]);
		if (flavor_out != exp_flavor)
			report($sformatf("op %0d flavor %s, expected %s", k, flavor_out.name(),
				exp_flavor.name()));
		for (int i = 0; i < NUM_TANKS; i++)
		begin
			exp_level = level_t'(gold[base + 7 + i]);
			exp_led = led_e'(gold[base + 11][i]);
			if (tank_level[i] != exp_level)
				report($sformatf("op %0d tank %0d level %0d, expected %0d", k, i,
					tank_level[i], exp_level));
			if (tank_led[i] != exp_led)
				report($sformatf("op %0d tank %0d lamp %s, expected %s", k, i,
					tank_led[i].name(), exp_led.name()));
		end
	endtask

	initial
	begin
		errors = 0;
		results = 0;
		for (int i = 0; i < FIELDS * MAX_OPS; i++)
			gold[i] = '0;
		$readmemh("bench/brew_golden.dat", gold);
		n_ops = 0;
		// Kind 0 ends the table
		while (n_ops < MAX_OPS && gold[n_ops * FIELDS] != '0)
			n_ops++;
		@(posedge rst_n);
		@(negedge clk);
		check_reset();
		// Outputs sampled mid-cycle
		forever
		begin
			@(negedge clk);
			if (out_valid)
			begin
				if (results >= n_ops)
				begin
					errors++;
					$display("Unexpected out_valid at time %0t after the last operation", $time);
				end
				else
					compare_result(results);
				results++;
			end
		end
	end

endmodule

/* bench/cm_tb.sv */
// Dispenser testbench top
module cm_tb import cm_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 10;
	localparam int FIELDS = 12;
	localparam int MAX_OPS = 64;
	// Watchdog budget per golden line
	localparam int OP_CYCLES = 40;
	localparam int RESULT_WAIT = 30;

	logic clk;
	logic rst_n;
	tank_e select_i;
	level_t supply;
	flavor_e flavor_btn;
	size_e required_size;
	logic out_valid;
	flavor_e flavor_out;
	level_t tank_level [NUM_TANKS];
	led_e tank_led [NUM_TANKS];

	logic [11:0] gold [0:FIELDS*MAX_OPS-1];
	int n_ops;
	int seed;
	int missing;
	int check_errors;
	int results;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	cm_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.select_i(select_i),
		.supply(supply),
		.flavor_btn(flavor_btn),
		.required_size(required_size),
		.out_valid(out_valid),
		.flavor_out(flavor_out),
		.tank_level(tank_level),
		.tank_led(tank_led)
	);

	cm_checker #(.FIELDS(FIELDS), .MAX_OPS(MAX_OPS)) u_check (
		.clk(clk),
		.rst_n(rst_n),
		.out_valid(out_valid),
		.flavor_out(flavor_out),
		.tank_level(tank_level),
		.tank_led(tank_led),
		.errors(check_errors),
		.results(results)
	);

	// ##############################
	// One golden line
	// ##############################
	task automatic run_op(input int k);
		int base;
		int kind;
		int waited;
		int gap;
		base = k * FIELDS;
		kind = int'(gold[base]);
		@(posedge clk);
		#DRIVE_DELAY;
		if (kind == 1)
		begin
			// Refill burst, one addition per cycle
			select_i = tank_e'(gold[base + 1][2:0]);
			supply = level_t'(gold[base + 2]);
			repeat (int'(gold[base + 3])) @(posedge clk);
			#DRIVE_DELAY;
			select_i = none;
			supply = '0;
		end
		else
		begin
			flavor_btn = flavor_e'(gold[base + 4][2:0]);
			required_size = size_e'(gold[base + 5][2:0]);
			@(posedge clk);
			#DRIVE_DELAY;
			if (kind == 3)
			begin
				// Presses while the divider runs
				select_i = tank_e'(3'(1 + ($unsigned($random(seed)) % 4)));
				supply = level_t'($random(seed));
				flavor_btn = mocha;
				required_size = xl;
				repeat (3) @(posedge clk);
				#DRIVE_DELAY;
				select_i = none;
				supply = '0;
			end
			flavor_btn = no_coffee;
			required_size = no_size;
		end
		waited = 0;
		while (!out_valid && waited < RESULT_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!out_valid)
		begin
			missing++;
			$display("No out_valid for operation %0d by time %0t", k, $time);
		end
		gap = int'($unsigned($random(seed)) % 4);
		repeat (gap) @(posedge clk);
	endtask

	initial
	begin
		select_i = none;
		supply = '0;
		flavor_btn = no_coffee;
		required_size = no_size;
		seed = 918;
		missing = 0;
		for (int i = 0; i < FIELDS * MAX_OPS; i++)
			gold[i] = '0;
		$readmemh("bench/brew_golden.dat", gold);
		n_ops = 0;
		while (n_ops < MAX_OPS && gold[n_ops * FIELDS] != '0)
			n_ops++;
		@(posedge rst_n);
		for (int k = 0; k < n_ops; k++)
			run_op(k);
		// Room for a stray pulse to show up
		repeat (5) @(posedge clk);
		$display("Operations %0d, results %0d, check errors %0d, missing results %0d",
			n_ops, results, check_errors, missing);
		if (check_errors == 0 && missing == 0 && results == n_ops && n_ops > 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog, sized from the golden table
	initial
	begin
		#1;
		#((n_ops * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired at time %0t before all operations finished", $time);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* list.f */
hw/cm_pkg.sv
hw/brew_if.sv
hw/order_sequencer.sv
hw/portion_divider.sv
hw/tank_bank.sv
hw/cm_top.sv
bench/tb_clock.sv
bench/cm_checker.sv
bench/cm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the dispenser simulation with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module cm_tb -f list.f -o cm_sim \
	&& ./obj_dir/cm_sim | tee sim.log \
	|| { echo "Build or simulation run did not complete"; exit 1; }

grep -q "^Testbench passed$" sim.log \
	&& echo "Simulation result: PASS" \
	|| { echo "Simulation result: FAIL"; exit 1; }

/* bench/brew_golden.dat */
// kind (1 refill, 2 brew, 3 brew with busy presses), select, supply, cycles, flavor, size
// then expected flavor, levels espresso milk chocolate froth, lamp bits with bit 0 espresso
1 1 064 5 0 0 0 1f4 000 000 000 1
1 2 050 5 0 0 0 1f4 190 000 000 3
1 3 03c 6 0 0 0 1f4 190 168 000 7
1 4 05a 4 0 0 0 1f4 190 168 168 f
2 0 000 0 1 1 1 194 160 168 108 f
2 0 000 0 2 1 2 11c 124 168 0cc f
2 0 000 0 3 1 3 0cc 0d4 118 0cc f
2 0 000 0 1 2 1 03c 08c 118 03c f
2 0 000 0 2 2 0 03c 08c 118 03c 6
1 1 064 7 0 0 0 2f8 08c 118 03c f
1 4 064 3 0 0 0 2f8 08c 118 168 f
1 2 078 5 0 0 0 2f8 2e4 118 168 f
2 0 000 0 2 2 2 244 28a 118 10e f
2 0 000 0 3 2 3 1cc 212 0a0 10e f
2 0 000 0 3 3 3 12c 172 000 10e b
2 0 000 0 3 4 0 12c 172 000 10e b
1 3 064 5 0 0 0 12c 172 1f4 10e f
2 0 000 0 1 3 1 06c 112 1f4 04e f
1 1 096 6 0 0 0 3f0 112 1f4 04e f
1 4 0c8 5 0 0 0 3f0 112 1f4 036 f
1 4 064 4 0 0 0 3f0 112 1f4 1c6 f
3 0 000 0 1 4 1 300 09a 1f4 0d6 f
2 0 000 0 2 3 2 210 022 1f4 05e f
1 2 0c8 4 0 0 0 210 342 1f4 05e f
1 4 064 3 0 0 0 210 342 1f4 18a f
2 0 000 0 2 4 2 0e4 2ac 1f4 0f4 f
3 0 000 0 2 4 0 0e4 2ac 1f4 0f4 e
3 0 000 0 3 4 3 01c 1e4 12c 0f4 f
2 0 000 0 1 1 0 01c 1e4 12c 0f4 e
